//--- logic/xbar_pkg.sv
`default_nettype none

package xbar_pkg;

    localparam int num_masters = 2;
    localparam int num_slaves  = 2;
    localparam int id_width    = 1;
    // slave side carries the master index in front of the id
    localparam int sid_width   = id_width + $clog2(num_masters);
    localparam int addr_width  = 32;
    localparam int data_width  = 32;
    localparam int strb_width  = data_width / 8;

    typedef logic [id_width-1:0]            id_t;
    typedef logic [sid_width-1:0]           sid_t;
    typedef logic [addr_width-1:0]          addr_t;
    typedef logic [data_width-1:0]          data_t;
    typedef logic [strb_width-1:0]          strb_t;
    typedef logic [3:0]                     len_t;
    typedef logic [2:0]                     size_t;
    typedef logic [1:0]                     burst_t;
    typedef logic [1:0]                     resp_t;
    typedef logic [$clog2(num_masters)-1:0] port_sel_t;

    typedef struct packed {
        id_t    id;
        addr_t  addr;
        len_t   len;
        size_t  size;
        burst_t burst;
        logic   valid;
    } addr_m_t;

    typedef struct packed {
        sid_t   sid;
        addr_t  addr;
        len_t   len;
        size_t  size;
        burst_t burst;
        logic   valid;
    } addr_s_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        strb_t strb;
        logic  last;
        logic  valid;
    } wdata_m_t;

    typedef struct packed {
        sid_t  sid;
        data_t data;
        strb_t strb;
        logic  last;
        logic  valid;
    } wdata_s_t;

    typedef struct packed {
        sid_t  sid;
        resp_t resp;
        logic  valid;
    } bresp_s_t;

    typedef struct packed {
        id_t   id;
        resp_t resp;
        logic  valid;
    } bresp_m_t;

    typedef struct packed {
        sid_t  sid;
        data_t data;
        resp_t resp;
        logic  last;
        logic  valid;
    } rdata_s_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
        logic  valid;
    } rdata_m_t;

    // one selector pair
    typedef struct packed {
        port_sel_t sel;
        logic      en;
    } route_t;

endpackage

`default_nettype wire

//--- logic/addr_switch.sv
`timescale 1ns/1ps
`default_nettype none

module addr_switch (
    input  wire xbar_pkg::addr_m_t           m_req   [xbar_pkg::num_masters],
    output logic [xbar_pkg::num_masters-1:0] m_ready,
    input  wire xbar_pkg::route_t            route   [xbar_pkg::num_masters],
    output xbar_pkg::addr_s_t                s_req   [xbar_pkg::num_slaves],
    input  wire [xbar_pkg::num_slaves-1:0]   s_ready
);

    logic [xbar_pkg::num_slaves-1:0] owned;
    xbar_pkg::port_sel_t             owner [xbar_pkg::num_slaves];

    // owner per slave, scanned high to low so master 0 wins
    always_comb begin
        for (int s = 0; s < xbar_pkg::num_slaves; s++) begin
            owned[s] = 1'b0;
            owner[s] = '0;
            for (int m = xbar_pkg::num_masters - 1; m >= 0; m--) begin
                if (route[m].en && int'(route[m].sel) == s) begin
                    owned[s] = 1'b1;
                    owner[s] = xbar_pkg::port_sel_t'(m);
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < xbar_pkg::num_slaves; s++) begin
            s_req[s] = '0;
            if (owned[s]) begin
                s_req[s].sid   = {owner[s], m_req[owner[s]].id};
                s_req[s].addr  = m_req[owner[s]].addr;
                s_req[s].len   = m_req[owner[s]].len;
                s_req[s].size  = m_req[owner[s]].size;
                s_req[s].burst = m_req[owner[s]].burst;
                s_req[s].valid = m_req[owner[s]].valid;
            end
        end
    end

    // a losing master sees ready low
    always_comb begin
        for (int m = 0; m < xbar_pkg::num_masters; m++) begin
            m_ready[m] = 1'b0;
            if (route[m].en && int'(owner[route[m].sel]) == m) begin
                m_ready[m] = s_ready[route[m].sel];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/wdata_switch.sv
`timescale 1ns/1ps
`default_nettype none

module wdata_switch (
    input  wire xbar_pkg::wdata_m_t          m_beat  [xbar_pkg::num_masters],
    output logic [xbar_pkg::num_masters-1:0] m_ready,
    input  wire xbar_pkg::route_t            route   [xbar_pkg::num_masters],
    output xbar_pkg::wdata_s_t               s_beat  [xbar_pkg::num_slaves],
    input  wire [xbar_pkg::num_slaves-1:0]   s_ready
);

    logic [xbar_pkg::num_slaves-1:0] owned;
    xbar_pkg::port_sel_t             owner [xbar_pkg::num_slaves];

    // master 0 scanned last, so it takes a contested slave
    always_comb begin
        for (int s = 0; s < xbar_pkg::num_slaves; s++) begin
            owned[s] = 1'b0;
            owner[s] = '0;
            for (int m = xbar_pkg::num_masters - 1; m >= 0; m--) begin
                if (route[m].en && int'(route[m].sel) == s) begin
                    owned[s] = 1'b1;
                    owner[s] = xbar_pkg::port_sel_t'(m);
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < xbar_pkg::num_slaves; s++) begin
            s_beat[s] = '0;
            if (owned[s]) begin
                s_beat[s].sid   = {owner[s], m_beat[owner[s]].id};
                s_beat[s].data  = m_beat[owner[s]].data;
                s_beat[s].strb  = m_beat[owner[s]].strb;
                s_beat[s].last  = m_beat[owner[s]].last;
                s_beat[s].valid = m_beat[owner[s]].valid;
            end
        end
    end

    always_comb begin
        for (int m = 0; m < xbar_pkg::num_masters; m++) begin
            m_ready[m] = 1'b0;
            if (route[m].en && int'(owner[route[m].sel]) == m) begin
                m_ready[m] = s_ready[route[m].sel];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/bresp_switch.sv
`timescale 1ns/1ps
`default_nettype none

module bresp_switch (
    input  wire xbar_pkg::bresp_s_t          s_resp  [xbar_pkg::num_slaves],
    output logic [xbar_pkg::num_slaves-1:0]  s_ready,
    input  wire xbar_pkg::route_t            route   [xbar_pkg::num_slaves],
    output xbar_pkg::bresp_m_t               m_resp  [xbar_pkg::num_masters],
    input  wire [xbar_pkg::num_masters-1:0]  m_ready
);

    logic [xbar_pkg::num_masters-1:0] claimed;
    xbar_pkg::port_sel_t              winner [xbar_pkg::num_masters];

    // slave 0 wins when both slaves claim one master
    always_comb begin
        for (int m = 0; m < xbar_pkg::num_masters; m++) begin
            claimed[m] = 1'b0;
            winner[m]  = '0;
            for (int s = xbar_pkg::num_slaves - 1; s >= 0; s--) begin
                if (route[s].en && int'(route[s].sel) == m) begin
                    claimed[m] = 1'b1;
                    winner[m]  = xbar_pkg::port_sel_t'(s);
                end
            end
        end
    end

    // master index dropped from the id on the way back
    always_comb begin
        for (int m = 0; m < xbar_pkg::num_masters; m++) begin
            m_resp[m] = '0;
            if (claimed[m]) begin
                m_resp[m].id    = s_resp[winner[m]].sid[xbar_pkg::id_width-1:0];
                m_resp[m].resp  = s_resp[winner[m]].resp;
                m_resp[m].valid = s_resp[winner[m]].valid;
            end
        end
    end

    // bready comes from the master this slave is routed to
    always_comb begin
        for (int s = 0; s < xbar_pkg::num_slaves; s++) begin
            s_ready[s] = 1'b0;
            if (route[s].en && int'(winner[route[s].sel]) == s) begin
                s_ready[s] = m_ready[route[s].sel];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rdata_switch.sv
`timescale 1ns/1ps
`default_nettype none

module rdata_switch (
    input  wire xbar_pkg::rdata_s_t          s_beat  [xbar_pkg::num_slaves],
    output logic [xbar_pkg::num_slaves-1:0]  s_ready,
    input  wire xbar_pkg::route_t            route   [xbar_pkg::num_slaves],
    output xbar_pkg::rdata_m_t               m_beat  [xbar_pkg::num_masters],
    input  wire [xbar_pkg::num_masters-1:0]  m_ready
);

    logic [xbar_pkg::num_masters-1:0] claimed;
    xbar_pkg::port_sel_t              winner [xbar_pkg::num_masters];

    // winning slave per master, lowest index first
    always_comb begin
        for (int m = 0; m < xbar_pkg::num_masters; m++) begin
            claimed[m] = 1'b0;
            winner[m]  = '0;
            for (int s = xbar_pkg::num_slaves - 1; s >= 0; s--) begin
                if (route[s].en && int'(route[s].sel) == m) begin
                    claimed[m] = 1'b1;
                    winner[m]  = xbar_pkg::port_sel_t'(s);
                end
            end
        end
    end

    always_comb begin
        for (int m = 0; m < xbar_pkg::num_masters; m++) begin
            m_beat[m] = '0;
            if (claimed[m]) begin
                // low bits of sid are the master's own id
                m_beat[m].id    = s_beat[winner[m]].sid[xbar_pkg::id_width-1:0];
                m_beat[m].data  = s_beat[winner[m]].data;
                m_beat[m].resp  = s_beat[winner[m]].resp;
                m_beat[m].last  = s_beat[winner[m]].last;
                m_beat[m].valid = s_beat[winner[m]].valid;
            end
        end
    end

    // losing slave is held off with ready low
    always_comb begin
        for (int s = 0; s < xbar_pkg::num_slaves; s++) begin
            s_ready[s] = 1'b0;
            if (route[s].en && int'(winner[route[s].sel]) == s) begin
                s_ready[s] = m_ready[route[s].sel];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

module axi_crossbar (
    // write address
    input  wire xbar_pkg::addr_m_t           aw_m       [xbar_pkg::num_masters],
    output logic [xbar_pkg::num_masters-1:0] aw_m_ready,
    output xbar_pkg::addr_s_t                aw_s       [xbar_pkg::num_slaves],
    input  wire [xbar_pkg::num_slaves-1:0]   aw_s_ready,

    // write data
    input  wire xbar_pkg::wdata_m_t          w_m        [xbar_pkg::num_masters],
    output logic [xbar_pkg::num_masters-1:0] w_m_ready,
    output xbar_pkg::wdata_s_t               w_s        [xbar_pkg::num_slaves],
    input  wire [xbar_pkg::num_slaves-1:0]   w_s_ready,

    // write response
    input  wire xbar_pkg::bresp_s_t          b_s        [xbar_pkg::num_slaves],
    output logic [xbar_pkg::num_slaves-1:0]  b_s_ready,
    output xbar_pkg::bresp_m_t               b_m        [xbar_pkg::num_masters],
    input  wire [xbar_pkg::num_masters-1:0]  b_m_ready,

    // read address
    input  wire xbar_pkg::addr_m_t           ar_m       [xbar_pkg::num_masters],
    output logic [xbar_pkg::num_masters-1:0] ar_m_ready,
    output xbar_pkg::addr_s_t                ar_s       [xbar_pkg::num_slaves],
    input  wire [xbar_pkg::num_slaves-1:0]   ar_s_ready,

    // read data
    input  wire xbar_pkg::rdata_s_t          r_s        [xbar_pkg::num_slaves],
    output logic [xbar_pkg::num_slaves-1:0]  r_s_ready,
    output xbar_pkg::rdata_m_t               r_m        [xbar_pkg::num_masters],
    input  wire [xbar_pkg::num_masters-1:0]  r_m_ready,

    // selectors, per master on forward channels and per slave on return
    input  wire xbar_pkg::route_t            aw_route   [xbar_pkg::num_masters],
    input  wire xbar_pkg::route_t            w_route    [xbar_pkg::num_masters],
    input  wire xbar_pkg::route_t            ar_route   [xbar_pkg::num_masters],
    input  wire xbar_pkg::route_t            b_route    [xbar_pkg::num_slaves],
    input  wire xbar_pkg::route_t            r_route    [xbar_pkg::num_slaves]
);

    addr_switch i_aw_switch (
        .m_req   (aw_m),
        .m_ready (aw_m_ready),
        .route   (aw_route),
        .s_req   (aw_s),
        .s_ready (aw_s_ready)
    );

    wdata_switch i_w_switch (
        .m_beat  (w_m),
        .m_ready (w_m_ready),
        .route   (w_route),
        .s_beat  (w_s),
        .s_ready (w_s_ready)
    );

    // bready follows the write response routes
    bresp_switch i_b_switch (
        .s_resp  (b_s),
        .s_ready (b_s_ready),
        .route   (b_route),
        .m_resp  (b_m),
        .m_ready (b_m_ready)
    );

    addr_switch i_ar_switch (
        .m_req   (ar_m),
        .m_ready (ar_m_ready),
        .route   (ar_route),
        .s_req   (ar_s),
        .s_ready (ar_s_ready)
    );

    rdata_switch i_r_switch (
        .s_beat  (r_s),
        .s_ready (r_s_ready),
        .route   (r_route),
        .m_beat  (r_m),
        .m_ready (r_m_ready)
    );

endmodule

`default_nettype wire

//--- testbench/crossbar_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module crossbar_asserts (
    input wire                               clk,
    input wire                               rst,
    input wire xbar_pkg::addr_m_t            aw_m [xbar_pkg::num_masters],
    input wire xbar_pkg::addr_m_t            ar_m [xbar_pkg::num_masters],
    input wire xbar_pkg::addr_s_t            aw_s [xbar_pkg::num_slaves],
    input wire xbar_pkg::addr_s_t            ar_s [xbar_pkg::num_slaves],
    input wire xbar_pkg::wdata_m_t           w_m  [xbar_pkg::num_masters],
    input wire xbar_pkg::wdata_s_t           w_s  [xbar_pkg::num_slaves],
    input wire xbar_pkg::bresp_s_t           b_s  [xbar_pkg::num_slaves],
    input wire xbar_pkg::bresp_m_t           b_m  [xbar_pkg::num_masters],
    input wire xbar_pkg::rdata_s_t           r_s  [xbar_pkg::num_slaves],
    input wire xbar_pkg::rdata_m_t           r_m  [xbar_pkg::num_masters],
    input wire [xbar_pkg::num_masters-1:0]   aw_m_ready, w_m_ready, ar_m_ready, b_m_ready,
    input wire [xbar_pkg::num_masters-1:0]   r_m_ready,
    input wire [xbar_pkg::num_slaves-1:0]    aw_s_ready, w_s_ready, ar_s_ready, b_s_ready,
    input wire [xbar_pkg::num_slaves-1:0]    r_s_ready,
    input wire xbar_pkg::route_t             aw_route [xbar_pkg::num_masters],
    input wire xbar_pkg::route_t             w_route  [xbar_pkg::num_masters],
    input wire xbar_pkg::route_t             ar_route [xbar_pkg::num_masters],
    input wire xbar_pkg::route_t             b_route  [xbar_pkg::num_slaves],
    input wire xbar_pkg::route_t             r_route  [xbar_pkg::num_slaves]
);

    int fail_count = 0;

    xbar_pkg::addr_s_t  exp_aw [xbar_pkg::num_slaves];
    xbar_pkg::addr_s_t  exp_ar [xbar_pkg::num_slaves];
    xbar_pkg::wdata_s_t exp_w  [xbar_pkg::num_slaves];
    xbar_pkg::bresp_m_t exp_b  [xbar_pkg::num_masters];
    xbar_pkg::rdata_m_t exp_r  [xbar_pkg::num_masters];
    logic [9:0]         exp_ready;

    // lowest claiming index wins the far port
    function automatic xbar_pkg::route_t owner(xbar_pkg::route_t r [xbar_pkg::num_masters],
                                               int p);
        for (int i = 0; i < xbar_pkg::num_masters; i++) begin
            if (r[i].en && int'(r[i].sel) == p) begin
                return '{sel: xbar_pkg::port_sel_t'(i), en: 1'b1};
            end
        end
        return '0;
    endfunction

    function automatic logic granted(xbar_pkg::route_t r [xbar_pkg::num_masters],
                                     logic [1:0] far, int p);
        xbar_pkg::route_t o;
        o = owner(r, int'(r[p].sel));
        return r[p].en && o.en && int'(o.sel) == p && far[r[p].sel];
    endfunction

    always_comb begin
        for (int p = 0; p < xbar_pkg::num_slaves; p++) begin
            xbar_pkg::route_t o;
            // index in front of the id, remaining fields line up
            o = owner(aw_route, p);
            exp_aw[p] = o.en ? {o.sel, aw_m[o.sel]} : '0;
            o = owner(ar_route, p);
            exp_ar[p] = o.en ? {o.sel, ar_m[o.sel]} : '0;
            o = owner(w_route, p);
            exp_w[p] = o.en ? {o.sel, w_m[o.sel]} : '0;
            // top sid bits dropped on the way back
            o = owner(b_route, p);
            exp_b[p] = o.en ? b_s[o.sel][$bits(xbar_pkg::bresp_m_t)-1:0] : '0;
            o = owner(r_route, p);
            exp_r[p] = o.en ? r_s[o.sel][$bits(xbar_pkg::rdata_m_t)-1:0] : '0;
            exp_ready[p]     = granted(aw_route, aw_s_ready, p);
            exp_ready[p + 2] = granted(w_route, w_s_ready, p);
            exp_ready[p + 4] = granted(ar_route, ar_s_ready, p);
            exp_ready[p + 6] = granted(b_route, b_m_ready, p);
            exp_ready[p + 8] = granted(r_route, r_m_ready, p);
        end
    end

    property holds(ok);
        @(posedge clk) disable iff (rst) ok;
    endproperty

    for (genvar p = 0; p < xbar_pkg::num_slaves; p++) begin : g_port
        a_aw: assert property (holds(aw_s[p] == exp_aw[p])) else begin
            $error("FAIL %0t aw_s[%0d] expected %h got %h", $time, p, exp_aw[p], aw_s[p]);
            fail_count++;
        end
        a_ar: assert property (holds(ar_s[p] == exp_ar[p])) else begin
            $error("FAIL %0t ar_s[%0d] expected %h got %h", $time, p, exp_ar[p], ar_s[p]);
            fail_count++;
        end
        a_w: assert property (holds(w_s[p] == exp_w[p])) else begin
            $error("FAIL %0t w_s[%0d] expected %h got %h", $time, p, exp_w[p], w_s[p]);
            fail_count++;
        end
        a_b: assert property (holds(b_m[p] == exp_b[p])) else begin
            $error("FAIL %0t b_m[%0d] expected %h got %h", $time, p, exp_b[p], b_m[p]);
            fail_count++;
        end
        a_r: assert property (holds(r_m[p] == exp_r[p])) else begin
            $error("FAIL %0t r_m[%0d] expected %h got %h", $time, p, exp_r[p], r_m[p]);
            fail_count++;
        end
    end

    a_ready: assert property (holds(
        {r_s_ready, b_s_ready, ar_m_ready, w_m_ready, aw_m_ready} == exp_ready)) else begin
        $error("FAIL %0t ready r_s/b_s/ar_m/w_m/aw_m expected %h got %h", $time, exp_ready,
               {r_s_ready, b_s_ready, ar_m_ready, w_m_ready, aw_m_ready});
        fail_count++;
    end

endmodule

`default_nettype wire

//--- testbench/crossbar_tb.sv
`timescale 1ns/1ps
`default_nettype none

module crossbar_tb;

    logic clk = 1'b0;
    logic rst = 1'b1;

    xbar_pkg::addr_m_t  aw_m [xbar_pkg::num_masters];
    xbar_pkg::addr_m_t  ar_m [xbar_pkg::num_masters];
    xbar_pkg::addr_s_t  aw_s [xbar_pkg::num_slaves];
    xbar_pkg::addr_s_t  ar_s [xbar_pkg::num_slaves];
    xbar_pkg::wdata_m_t w_m  [xbar_pkg::num_masters];
    xbar_pkg::wdata_s_t w_s  [xbar_pkg::num_slaves];
    xbar_pkg::bresp_s_t b_s  [xbar_pkg::num_slaves];
    xbar_pkg::bresp_m_t b_m  [xbar_pkg::num_masters];
    xbar_pkg::rdata_s_t r_s  [xbar_pkg::num_slaves];
    xbar_pkg::rdata_m_t r_m  [xbar_pkg::num_masters];
    xbar_pkg::route_t   aw_route [xbar_pkg::num_masters];
    xbar_pkg::route_t   w_route  [xbar_pkg::num_masters];
    xbar_pkg::route_t   ar_route [xbar_pkg::num_masters];
    xbar_pkg::route_t   b_route  [xbar_pkg::num_slaves];
    xbar_pkg::route_t   r_route  [xbar_pkg::num_slaves];
    logic [1:0]         aw_m_ready, w_m_ready, ar_m_ready, b_s_ready, r_s_ready;
    logic [1:0]         aw_s_ready, w_s_ready, ar_s_ready, b_m_ready, r_m_ready;
    int                 hits [6];

    always #20 clk = ~clk;

    bind axi_crossbar crossbar_asserts i_asserts (
        .clk(crossbar_tb.clk), .rst(crossbar_tb.rst), .*);

    axi_crossbar i_axi_crossbar (.*);

    // zero or fresh random values on every crossbar input
    task automatic drive_inputs(input logic zero);
        logic [191:0] r;
        for (int i = 0; i < 2; i++) begin
            r = zero ? '0 : {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
            aw_m[i]       = r[42:0];
            ar_m[i]       = r[85:43];
            w_m[i]        = r[124:86];
            b_s[i]        = r[129:125];
            r_s[i]        = r[167:130];
            aw_route[i]   = r[169:168];
            w_route[i]    = r[171:170];
            ar_route[i]   = r[173:172];
            b_route[i]    = r[175:174];
            r_route[i]    = r[177:176];
            aw_s_ready[i] = r[178];
            w_s_ready[i]  = r[179];
            ar_s_ready[i] = r[180];
            b_m_ready[i]  = r[181];
            r_m_ready[i]  = r[182];
        end
    endtask

    initial begin
        void'($urandom(69));
        drive_inputs(1'b1);
        forever begin
            @(posedge clk);
            #2;
            drive_inputs(rst);
        end
    end

    // stimulus that reaches each checked behavior
    always @(posedge clk) begin
        if (!rst) begin
            hits[0] += int'(ar_route[1].en && ar_m[1].valid &&
                            !(ar_route[0].en && ar_route[0].sel == ar_route[1].sel));
            hits[1] += int'(aw_route[0].en && aw_route[1].en &&
                            aw_route[0].sel == aw_route[1].sel);
            hits[2] += int'(!ar_route[0].en && !ar_route[1].en);
            hits[3] += int'(w_route[1].en && w_m[1].valid && w_m[1].last &&
                            !(w_route[0].en && w_route[0].sel == w_route[1].sel));
            hits[4] += int'(r_route[0].en && r_route[1].en &&
                            r_route[0].sel == r_route[1].sel);
            hits[5] += int'(b_route[0].en && b_s[0].valid && !b_m_ready[b_route[0].sel]);
        end
    end

    always @(posedge clk) begin
        if (i_axi_crossbar.i_asserts.fail_count != 0) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "routing assertion failed");
        end
    end

    task automatic wait_for_hits(input int idx, input string what);
        int cycles;
        cycles = 0;
        while (hits[idx] < 8 && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (hits[idx] < 8) begin
            $display("behavior never reached: %s", what);
            $display("TESTBENCH FAILED");
            $fatal(1, "coverage timeout");
        end
    endtask

    initial begin
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        wait_for_hits(0, "read address slave owned by master 1 alone");
        wait_for_hits(1, "both masters routing write address to one slave");
        wait_for_hits(2, "read address slaves with no owner");
        wait_for_hits(3, "last write beat from master 1");
        wait_for_hits(4, "both slaves claiming one master for read data");
        wait_for_hits(5, "write response held off by master ready");
        // let the last sampled edge finish its checks
        repeat (2) @(posedge clk);
        #1;
        if (i_axi_crossbar.i_asserts.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "routing assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- list.f
logic/xbar_pkg.sv
logic/addr_switch.sv
logic/wdata_switch.sv
logic/bresp_switch.sv
logic/rdata_switch.sv
logic/axi_crossbar.sv
testbench/crossbar_asserts.sv
testbench/crossbar_tb.sv
